//--- src.f
common/core_pkg.sv
rtl/l1_data_cache/l1_data_cache.sv
rtl/store_buffer/store_buffer.sv
rtl/load_merge.sv
rtl/l2_request_arbiter.sv
rtl/mem_core.sv
test/mem_core_tb.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -Wno-fatal --top-module mem_core_tb \
		-f src.f -o mem_core_sim \
	&& ./obj_dir/mem_core_sim | tee /dev/stderr | grep -q "Verification passed" \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }

//--- test/mem_core_tb.sv
`timescale 1ns/1ps

module mem_core_tb;

	localparam ADDR_W = 26;
	localparam NOPS = 16;
	localparam MAX_DELAY = 8;
	localparam CLS_HIT = 0;
	localparam CLS_MISS = 1;
	localparam CLS_ROLLBACK = 2;
	localparam CLS_ANY = 3;
	localparam TIMEOUT_NS = (NOPS * (4 * MAX_DELAY + 20) + 20) * 40;

	logic clk = 1'b0;
	logic reset;
	logic load;
	logic store;
	logic [1:0] strand;
	logic [ADDR_W-1:0] addr;
	logic [1:0] lane;
	core_pkg::line_t st_data;
	logic [15:0] st_mask;
	logic [31:0] load_data;
	logic hit;
	logic load_collision;
	logic rollback;
	logic [3:0] load_complete;
	logic [3:0] store_resume;

	logic l2req_valid;
	logic l2req_ready;
	core_pkg::l2_unit_e l2req_unit;
	logic [1:0] l2req_strand;
	core_pkg::l2_op_e l2req_op;
	logic [ADDR_W-1:0] l2req_address;
	core_pkg::line_t l2req_data;
	logic [15:0] l2req_mask;

	logic l2rsp_valid;
	logic [1:0] l2rsp_core;
	logic l2rsp_status;
	core_pkg::l2_unit_e l2rsp_unit;
	logic [1:0] l2rsp_strand;
	core_pkg::l2_op_e l2rsp_op;
	logic l2rsp_update;
	logic [ADDR_W-1:0] l2rsp_address;
	core_pkg::line_t l2rsp_data;

	// Operation table
	logic op_is_store [NOPS];
	logic [1:0] op_strand [NOPS];
	logic [ADDR_W-1:0] op_addr [NOPS];
	logic [1:0] op_lane [NOPS];
	logic [31:0] op_data [NOPS];
	logic [15:0] op_mask [NOPS];
	int op_cls [NOPS];
	int op_count = 0;

	// L2 memory and reference state
	core_pkg::line_t mem [64];
	logic [7:0] ref_valid;
	logic [ADDR_W-1:0] ref_addr [8];
	core_pkg::line_t ref_line [8];
	logic [3:0] ref_pend;
	logic [3:0] ref_issued;
	logic [ADDR_W-1:0] ref_paddr [4];
	core_pkg::line_t ref_pdata [4];
	logic [15:0] ref_pmask [4];
	logic miss_out;
	logic miss_issued;
	logic [1:0] miss_strand;
	logic [ADDR_W-1:0] miss_addr;

	// Scheduled L2 responses
	int q_due [$];
	logic [1:0] q_strand [$];
	logic [ADDR_W-1:0] q_addr [$];
	logic q_fill [$];

	logic [3:0] exp_complete;
	logic [3:0] exp_resume;
	logic [3:0] seen_complete;
	logic hold_valid;
	logic [176:0] hold_payload;
	logic [31:0] rng = 32'd47;
	int cycle_n = 0;
	int errors = 0;
	int checks = 0;
	int n_store_req = 0;
	int n_load_req = 0;
	int n_accepted = 0;
	int n_miss = 0;

	wire [176:0] req_payload = {l2req_unit, l2req_strand, l2req_op, l2req_address,
		l2req_data, l2req_mask};

	mem_core #(.ADDR_W(ADDR_W), .CORE_ID(0), .CORE_W(2), .SETS(8)) uut(
		.clk(clk), .reset(reset),
		.load_i(load), .store_i(store), .strand_i(strand), .addr_i(addr), .lane_i(lane),
		.store_data_i(st_data), .store_mask_i(st_mask),
		.load_data_o(load_data), .hit_o(hit), .load_collision_o(load_collision),
		.rollback_o(rollback), .load_complete_strands_o(load_complete),
		.store_resume_strands_o(store_resume),
		.l2req_valid_o(l2req_valid), .l2req_ready_i(l2req_ready), .l2req_unit_o(l2req_unit),
		.l2req_strand_o(l2req_strand), .l2req_op_o(l2req_op),
		.l2req_address_o(l2req_address), .l2req_data_o(l2req_data), .l2req_mask_o(l2req_mask),
		.l2rsp_valid_i(l2rsp_valid), .l2rsp_core_i(l2rsp_core), .l2rsp_status_i(l2rsp_status),
		.l2rsp_unit_i(l2rsp_unit), .l2rsp_strand_i(l2rsp_strand), .l2rsp_op_i(l2rsp_op),
		.l2rsp_update_i(l2rsp_update), .l2rsp_address_i(l2rsp_address),
		.l2rsp_data_i(l2rsp_data));

	always #20 clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic core_pkg::line_t line_pattern(input logic [ADDR_W-1:0] a);
		core_pkg::line_t l;
		for (int w = 0; w < 4; w++)
			l.words[w] = 32'h5a00_0000 ^ (32'(a) * 32'h0001_0103) ^ (32'(w) << 20);
		return l;
	endfunction

	function automatic core_pkg::line_t make_line(input logic [31:0] d);
		core_pkg::line_t l;
		for (int w = 0; w < 4; w++)
			l.words[w] = d ^ (32'(w) * 32'h1111_1111);
		return l;
	endfunction

	// Masked bytes come from the new line
	function automatic core_pkg::line_t merge_line(input core_pkg::line_t base,
		input core_pkg::line_t upd, input logic [15:0] mask);
		for (int b = 0; b < 16; b++)
			if (mask[b])
				base.bytes[b] = upd.bytes[b];
		return base;
	endfunction

	// Store entry as the DUT sees it at the coming edge
	function automatic logic pending_at_edge(input logic [1:0] s);
		return ref_pend[s] || exp_resume[s];
	endfunction

	function automatic logic [31:0] expect_word(input logic [1:0] s,
		input logic [ADDR_W-1:0] a, input logic [1:0] ln);
		core_pkg::line_t l;
		l = ref_line[a[2:0]];
		if (pending_at_edge(s) && ref_paddr[s] == a)
			l = merge_line(l, ref_pdata[s], ref_pmask[s]);
		return l.words[ln];
	endfunction

	task automatic check_val(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("CHECK FAILED at %0t: %s is %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		checks++;
		assert (cond)
		else
		begin
			errors++;
			$display("%s at %0t", what, $time);
		end
	endtask

	task automatic add_op(input logic is_store, input logic [1:0] s, input int a,
		input logic [1:0] ln, input logic [31:0] d, input logic [15:0] m, input int cls);
		op_is_store[op_count] = is_store;
		op_strand[op_count] = s;
		op_addr[op_count] = ADDR_W'(a);
		op_lane[op_count] = ln;
		op_data[op_count] = d;
		op_mask[op_count] = m;
		op_cls[op_count] = cls;
		op_count++;
	endtask

	task automatic schedule_response(input logic [1:0] s, input logic [ADDR_W-1:0] a,
		input logic f);
		rng = xorshift32(rng);
		q_due.push_back(cycle_n + 1 + int'(rng % MAX_DELAY));
		q_strand.push_back(s);
		q_addr.push_back(a);
		q_fill.push_back(f);
	endtask

	// One cycle of the L2 model
	task automatic l2_step();
		logic [1:0] s;
		logic [ADDR_W-1:0] a;
		logic f;
		if (hold_valid)
			check_true(l2req_valid && req_payload == hold_payload,
				"L2 request dropped or changed while stalled");
		rng = xorshift32(rng);
		l2req_ready = rng[1:0] != 2'd0;	// Back-pressure for the coming edge
		hold_valid = l2req_valid && !l2req_ready;
		hold_payload = req_payload;
		if (l2req_valid && l2req_ready)
		begin
			s = l2req_strand;
			if (l2req_op == core_pkg::L2_OP_STORE)
			begin
				n_store_req++;
				check_true(ref_pend[s] && !ref_issued[s], "Store request with no waiting entry");
				check_val("l2req_unit_o", 128'(l2req_unit), 128'(core_pkg::UNIT_STBUF));
				check_val("l2req_address_o", 128'(l2req_address), 128'(ref_paddr[s]));
				check_val("l2req_data_o", l2req_data, ref_pdata[s]);
				check_val("l2req_mask_o", 128'(l2req_mask), 128'(ref_pmask[s]));
				ref_issued[s] = 1'b1;
				mem[l2req_address[5:0]] = merge_line(mem[l2req_address[5:0]], l2req_data,
					l2req_mask);
				schedule_response(s, l2req_address, 1'b0);
			end
			else
			begin
				n_load_req++;
				check_true(miss_out && !miss_issued, "Load request with no outstanding miss");
				check_val("l2req_unit_o", 128'(l2req_unit), 128'(core_pkg::UNIT_DCACHE));
				check_val("l2req_address_o", 128'(l2req_address), 128'(miss_addr));
				check_val("l2req_strand_o", 128'(s), 128'(miss_strand));
				miss_issued = 1'b1;
				schedule_response(s, l2req_address, 1'b1);
			end
		end

		l2rsp_valid = 1'b0;
		exp_complete = '0;
		exp_resume = '0;
		rng = xorshift32(rng);
		if (q_due.size() > 0 && q_due[0] <= cycle_n)
		begin
			void'(q_due.pop_front());
			s = q_strand.pop_front();
			a = q_addr.pop_front();
			f = q_fill.pop_front();
			l2rsp_valid = 1'b1;
			l2rsp_core = 2'd0;
			l2rsp_status = 1'b1;
			l2rsp_strand = s;
			l2rsp_address = a;
			l2rsp_data = mem[a[5:0]];
			if (f)
			begin
				l2rsp_unit = core_pkg::UNIT_DCACHE;
				l2rsp_op = core_pkg::L2_OP_LOAD;
				l2rsp_update = 1'b0;
				ref_valid[a[2:0]] = 1'b1;
				ref_addr[a[2:0]] = a;
				ref_line[a[2:0]] = mem[a[5:0]];
				miss_out = 1'b0;
				exp_complete = 4'(1) << s;
			end
			else
			begin
				l2rsp_unit = core_pkg::UNIT_STBUF;
				l2rsp_op = core_pkg::L2_OP_STORE;
				l2rsp_update = 1'b1;
				if (ref_valid[a[2:0]] && ref_addr[a[2:0]] == a)
					ref_line[a[2:0]] = merge_line(ref_line[a[2:0]], mem[a[5:0]], ref_pmask[s]);
				ref_pend[s] = 1'b0;
				ref_issued[s] = 1'b0;
				exp_resume = 4'(1) << s;
			end
		end
		else if (rng[3:0] < 4'd4)
		begin
			// Traffic for some other core
			l2rsp_valid = 1'b1;
			l2rsp_core = 2'd1 + 2'(rng[5:4] % 2'd3);
			l2rsp_status = 1'b1;
			l2rsp_unit = rng[6] ? core_pkg::UNIT_STBUF : core_pkg::UNIT_DCACHE;
			l2rsp_op = rng[6] ? core_pkg::L2_OP_STORE : core_pkg::L2_OP_LOAD;
			l2rsp_update = 1'b1;
			l2rsp_strand = rng[9:8];
			l2rsp_address = ADDR_W'(rng[15:10]);
			l2rsp_data = {4{rng}};
		end
	endtask

	task automatic cycle();
		@(negedge clk);
		check_val("load_complete_strands_o", 128'(load_complete), 128'(exp_complete));
		check_val("store_resume_strands_o", 128'(store_resume), 128'(exp_resume));
		seen_complete = seen_complete | load_complete;
		l2_step();
		cycle_n++;
	endtask

	task automatic drive_load(input logic [1:0] s, input logic [ADDR_W-1:0] a,
		input logic [1:0] ln, output logic exp_hit);
		logic [31:0] exp_word;
		exp_hit = ref_valid[a[2:0]] && ref_addr[a[2:0]] == a;
		exp_word = expect_word(s, a, ln);
		load = 1'b1;
		strand = s;
		addr = a;
		lane = ln;
		cycle();
		check_val("hit_o", 128'(hit), 128'(exp_hit));
		if (exp_hit)
			check_val("load_data_o", 128'(load_data), 128'(exp_word));
		else
		begin
			check_val("load_collision_o", 128'(load_collision), 128'(0));
			miss_out = 1'b1;
			miss_issued = 1'b0;
			miss_strand = s;
			miss_addr = a;
			n_miss++;
		end
		load = 1'b0;
	endtask

	task automatic do_load(input int i);
		logic was_hit;
		seen_complete[op_strand[i]] = 1'b0;
		drive_load(op_strand[i], op_addr[i], op_lane[i], was_hit);
		check_true(was_hit == (op_cls[i] == CLS_HIT) || op_cls[i] == CLS_ANY,
			$sformatf("Load %0d hit/miss differs from its table entry", i));
		if (!was_hit)
		begin
			while (!seen_complete[op_strand[i]])
				cycle();
			drive_load(op_strand[i], op_addr[i], op_lane[i], was_hit);
		end
	endtask

	task automatic do_store(input int i);
		logic [1:0] s;
		logic exp_rb;
		s = op_strand[i];
		if (op_cls[i] != CLS_ROLLBACK)
			while (pending_at_edge(s))
				cycle();
		exp_rb = pending_at_edge(s);
		check_true(exp_rb == (op_cls[i] == CLS_ROLLBACK),
			$sformatf("Store %0d cannot reach its table outcome", i));
		store = 1'b1;
		strand = s;
		addr = op_addr[i];
		st_data = make_line(op_data[i]);
		st_mask = op_mask[i];
		if (!exp_rb)
		begin
			ref_pend[s] = 1'b1;
			ref_issued[s] = 1'b0;
			ref_paddr[s] = op_addr[i];
			ref_pdata[s] = make_line(op_data[i]);
			ref_pmask[s] = op_mask[i];
			n_accepted++;
		end
		cycle();
		check_val("rollback_o", 128'(rollback), 128'(exp_rb));
		store = 1'b0;
	endtask

	initial
	begin
		#(TIMEOUT_NS);
		$display("Watchdog expired after %0d ns with the table not finished", TIMEOUT_NS);
		$display("Checks: %0d, errors: %0d", checks, errors);
		$display("Verification failed");
		$finish;
	end

	initial
	begin
		reset = 1'b1;
		load = 1'b0;
		store = 1'b0;
		strand = '0;
		addr = '0;
		lane = '0;
		st_data = '0;
		st_mask = '0;
		l2req_ready = 1'b0;
		l2rsp_valid = 1'b0;
		l2rsp_core = '0;
		l2rsp_status = 1'b0;
		l2rsp_unit = core_pkg::UNIT_DCACHE;
		l2rsp_strand = '0;
		l2rsp_op = core_pkg::L2_OP_LOAD;
		l2rsp_update = 1'b0;
		l2rsp_address = '0;
		l2rsp_data = '0;
		ref_valid = '0;
		ref_pend = '0;
		ref_issued = '0;
		miss_out = 1'b0;
		miss_issued = 1'b0;
		exp_complete = '0;
		exp_resume = '0;
		seen_complete = '0;
		hold_valid = 1'b0;
		for (int a = 0; a < 64; a++)
			mem[a] = line_pattern(ADDR_W'(a));

		add_op(0, 0, 3, 1, 0, 0, CLS_MISS);
		add_op(0, 0, 3, 2, 0, 0, CLS_HIT);
		add_op(1, 1, 3, 0, 32'hdead_0001, 16'h00f0, CLS_ANY);
		add_op(1, 1, 3, 0, 32'hbad0_0002, 16'hffff, CLS_ROLLBACK);
		add_op(0, 1, 3, 1, 0, 0, CLS_HIT);	// Sees its own pending store
		add_op(0, 2, 3, 1, 0, 0, CLS_HIT);
		add_op(0, 0, 11, 0, 0, 0, CLS_MISS);	// Evicts line 3
		add_op(1, 0, 11, 0, 32'hcafe_0003, 16'hffff, CLS_ANY);
		add_op(0, 3, 5, 3, 0, 0, CLS_MISS);
		add_op(1, 2, 5, 0, 32'h1234_0004, 16'h000f, CLS_ANY);
		add_op(1, 3, 20, 0, 32'h5555_0005, 16'hf000, CLS_ANY);
		add_op(0, 2, 5, 0, 0, 0, CLS_HIT);
		add_op(0, 0, 11, 2, 0, 0, CLS_HIT);
		add_op(0, 1, 3, 1, 0, 0, CLS_MISS);
		add_op(0, 1, 20, 3, 0, 0, CLS_MISS);
		add_op(0, 2, 3, 1, 0, 0, CLS_HIT);

		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		cycle();
		check_val("hit_o", 128'(hit), 128'(0));
		check_val("rollback_o", 128'(rollback), 128'(0));
		check_val("load_collision_o", 128'(load_collision), 128'(0));
		check_val("l2req_valid_o", 128'(l2req_valid), 128'(0));

		for (int i = 0; i < op_count; i++)
		begin
			if (op_is_store[i])
				do_store(i);
			else
				do_load(i);
		end

		// Drain stores still on their way to L2
		while (ref_pend != '0 || q_due.size() != 0)
			cycle();
		repeat (2) cycle();
		check_val("store request count", 128'(n_store_req), 128'(n_accepted));
		check_val("load request count", 128'(n_load_req), 128'(n_miss));

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

//--- rtl/mem_core.sv
`timescale 1ns/1ps

module mem_core
	#(parameter ADDR_W = 26,
	parameter CORE_ID = 0,
	parameter CORE_W = 2,
	parameter SETS = 8)
	(input clk,
	input reset,

	// Pipeline side
	input load_i,
	input store_i,
	input [$clog2(core_pkg::STRANDS)-1:0] strand_i,
	input [ADDR_W-1:0] addr_i,
	input [$clog2(core_pkg::LINE_WORDS)-1:0] lane_i,
	input core_pkg::line_t store_data_i,
	input [core_pkg::LINE_BYTES-1:0] store_mask_i,
	output logic [31:0] load_data_o,
	output logic hit_o,
	output logic load_collision_o,
	output logic rollback_o,
	output logic [core_pkg::STRANDS-1:0] load_complete_strands_o,
	output logic [core_pkg::STRANDS-1:0] store_resume_strands_o,

	// L2 request
	output logic l2req_valid_o,
	input l2req_ready_i,
	output core_pkg::l2_unit_e l2req_unit_o,
	output logic [$clog2(core_pkg::STRANDS)-1:0] l2req_strand_o,
	output core_pkg::l2_op_e l2req_op_o,
	output logic [ADDR_W-1:0] l2req_address_o,
	output core_pkg::line_t l2req_data_o,
	output logic [core_pkg::LINE_BYTES-1:0] l2req_mask_o,

	// L2 response broadcast
	input l2rsp_valid_i,
	input [CORE_W-1:0] l2rsp_core_i,
	input l2rsp_status_i,
	input core_pkg::l2_unit_e l2rsp_unit_i,
	input [$clog2(core_pkg::STRANDS)-1:0] l2rsp_strand_i,
	input core_pkg::l2_op_e l2rsp_op_i,
	input l2rsp_update_i,
	input [ADDR_W-1:0] l2rsp_address_i,
	input core_pkg::line_t l2rsp_data_i);

	localparam STRAND_W = $clog2(core_pkg::STRANDS);

	core_pkg::line_t cache_line;
	core_pkg::line_t bypass_line;
	logic [core_pkg::LINE_BYTES-1:0] bypass_mask;
	logic [core_pkg::LINE_BYTES-1:0] ack_mask;

	logic cache_req_valid;
	logic cache_req_ready;
	logic [STRAND_W-1:0] cache_req_strand;
	logic [ADDR_W-1:0] cache_req_address;

	logic stbuf_req_valid;
	logic stbuf_req_ready;
	logic [STRAND_W-1:0] stbuf_req_strand;
	logic [ADDR_W-1:0] stbuf_req_address;
	core_pkg::line_t stbuf_req_data;
	logic [core_pkg::LINE_BYTES-1:0] stbuf_req_mask;

	wire l2rsp_valid_for_me = l2rsp_valid_i && l2rsp_core_i == CORE_W'(CORE_ID);

	// Only a successful store writes through into the cache
	wire cache_update = l2rsp_update_i && l2rsp_status_i
		&& l2rsp_op_i == core_pkg::L2_OP_STORE;

	l1_data_cache #(.ADDR_W(ADDR_W), .SETS(SETS)) dcache(
		.clk(clk),
		.reset(reset),
		.load_i(load_i),
		.strand_i(strand_i),
		.addr_i(addr_i),
		.line_o(cache_line),
		.hit_o(hit_o),
		.load_collision_o(load_collision_o),
		.load_complete_strands_o(load_complete_strands_o),
		.l2req_valid_o(cache_req_valid),
		.l2req_ready_i(cache_req_ready),
		.l2req_strand_o(cache_req_strand),
		.l2req_address_o(cache_req_address),
		.rsp_valid_i(l2rsp_valid_for_me),
		.rsp_unit_i(l2rsp_unit_i),
		.rsp_strand_i(l2rsp_strand_i),
		.rsp_update_i(cache_update),
		.rsp_address_i(l2rsp_address_i),
		.rsp_data_i(l2rsp_data_i),
		.rsp_mask_i(ack_mask));

	store_buffer #(.ADDR_W(ADDR_W)) stbuf(
		.clk(clk),
		.reset(reset),
		.store_i(store_i),
		.load_i(load_i),
		.strand_i(strand_i),
		.addr_i(addr_i),
		.store_data_i(store_data_i),
		.store_mask_i(store_mask_i),
		.bypass_data_o(bypass_line),
		.bypass_mask_o(bypass_mask),
		.rollback_o(rollback_o),
		.store_resume_strands_o(store_resume_strands_o),
		.ack_mask_o(ack_mask),
		.l2req_valid_o(stbuf_req_valid),
		.l2req_ready_i(stbuf_req_ready),
		.l2req_strand_o(stbuf_req_strand),
		.l2req_address_o(stbuf_req_address),
		.l2req_data_o(stbuf_req_data),
		.l2req_mask_o(stbuf_req_mask),
		.rsp_valid_i(l2rsp_valid_for_me),
		.rsp_unit_i(l2rsp_unit_i),
		.rsp_strand_i(l2rsp_strand_i));

	load_merge merge(
		.clk(clk),
		.reset(reset),
		.cache_line_i(cache_line),
		.bypass_line_i(bypass_line),
		.bypass_mask_i(bypass_mask),
		.lane_i(lane_i),
		.word_o(load_data_o));

	l2_request_arbiter #(.ADDR_W(ADDR_W)) arbiter(
		.clk(clk),
		.reset(reset),
		.l2req_ready_i(l2req_ready_i),
		.cache_valid_i(cache_req_valid),
		.cache_strand_i(cache_req_strand),
		.cache_address_i(cache_req_address),
		.cache_ready_o(cache_req_ready),
		.stbuf_valid_i(stbuf_req_valid),
		.stbuf_strand_i(stbuf_req_strand),
		.stbuf_address_i(stbuf_req_address),
		.stbuf_data_i(stbuf_req_data),
		.stbuf_mask_i(stbuf_req_mask),
		.stbuf_ready_o(stbuf_req_ready),
		.l2req_valid_o(l2req_valid_o),
		.l2req_unit_o(l2req_unit_o),
		.l2req_strand_o(l2req_strand_o),
		.l2req_op_o(l2req_op_o),
		.l2req_address_o(l2req_address_o),
		.l2req_data_o(l2req_data_o),
		.l2req_mask_o(l2req_mask_o));

endmodule

//--- rtl/l2_request_arbiter.sv
`timescale 1ns/1ps

module l2_request_arbiter
	#(parameter ADDR_W = 26)
	(input clk,
	input reset,
	input l2req_ready_i,

	// Cache source, loads only
	input cache_valid_i,
	input [$clog2(core_pkg::STRANDS)-1:0] cache_strand_i,
	input [ADDR_W-1:0] cache_address_i,
	output logic cache_ready_o,

	// Store buffer source
	input stbuf_valid_i,
	input [$clog2(core_pkg::STRANDS)-1:0] stbuf_strand_i,
	input [ADDR_W-1:0] stbuf_address_i,
	input core_pkg::line_t stbuf_data_i,
	input [core_pkg::LINE_BYTES-1:0] stbuf_mask_i,
	output logic stbuf_ready_o,

	// Shared L2 request channel
	output logic l2req_valid_o,
	output core_pkg::l2_unit_e l2req_unit_o,
	output logic [$clog2(core_pkg::STRANDS)-1:0] l2req_strand_o,
	output core_pkg::l2_op_e l2req_op_o,
	output logic [ADDR_W-1:0] l2req_address_o,
	output core_pkg::line_t l2req_data_o,
	output logic [core_pkg::LINE_BYTES-1:0] l2req_mask_o);

	logic grant_locked;
	logic grant_r;
	logic stbuf_first;	// Round-robin priority
	logic grant;	// High selects the store buffer

	always_comb
	begin
		if (grant_locked)
			grant = grant_r;
		else if (cache_valid_i && stbuf_valid_i)
			grant = stbuf_first;
		else
			grant = stbuf_valid_i;
	end

	assign l2req_valid_o = grant ? stbuf_valid_i : cache_valid_i;
	assign cache_ready_o = l2req_ready_i && !grant;
	assign stbuf_ready_o = l2req_ready_i && grant;

	assign l2req_unit_o = grant ? core_pkg::UNIT_STBUF : core_pkg::UNIT_DCACHE;
	assign l2req_op_o = grant ? core_pkg::L2_OP_STORE : core_pkg::L2_OP_LOAD;
	assign l2req_strand_o = grant ? stbuf_strand_i : cache_strand_i;
	assign l2req_address_o = grant ? stbuf_address_i : cache_address_i;
	assign l2req_data_o = grant ? stbuf_data_i : '0;	// Loads carry no data
	assign l2req_mask_o = grant ? stbuf_mask_i : '0;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			grant_locked <= 1'b0;
			grant_r <= 1'b0;
			stbuf_first <= 1'b0;
		end
		else if (l2req_valid_o && l2req_ready_i)
		begin
			grant_locked <= 1'b0;
			stbuf_first <= !grant;	// Other side goes first next time
		end
		else if (l2req_valid_o)
		begin
			// Stalled, keep this source until it gets through
			grant_locked <= 1'b1;
			grant_r <= grant;
		end
	end

endmodule

//--- rtl/load_merge.sv
`timescale 1ns/1ps

module load_merge
	(input clk,
	input reset,
	input core_pkg::line_t cache_line_i,
	input core_pkg::line_t bypass_line_i,
	input [core_pkg::LINE_BYTES-1:0] bypass_mask_i,
	input [$clog2(core_pkg::LINE_WORDS)-1:0] lane_i,
	output logic [31:0] word_o);

	localparam LANE_W = $clog2(core_pkg::LINE_WORDS);

	logic [LANE_W-1:0] lane_q;
	core_pkg::line_t merged;

	// Lane arrives with the request, data one cycle later
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			lane_q <= '0;
		else
			lane_q <= lane_i;
	end

	always_comb
	begin
		for (int i = 0; i < core_pkg::LINE_BYTES; i++)
		begin
			if (bypass_mask_i[i])
				merged.bytes[i] = bypass_line_i.bytes[i];	// Pending store wins
			else
				merged.bytes[i] = cache_line_i.bytes[i];
		end
	end

	assign word_o = merged.words[lane_q];

endmodule

//--- rtl/store_buffer/store_buffer.sv
`timescale 1ns/1ps

module store_buffer
	#(parameter ADDR_W = 26)
	(input clk,
	input reset,

	// Pipeline side
	input store_i,
	input load_i,
	input [$clog2(core_pkg::STRANDS)-1:0] strand_i,
	input [ADDR_W-1:0] addr_i,
	input core_pkg::line_t store_data_i,
	input [core_pkg::LINE_BYTES-1:0] store_mask_i,
	output core_pkg::line_t bypass_data_o,
	output logic [core_pkg::LINE_BYTES-1:0] bypass_mask_o,
	output logic rollback_o,
	output logic [core_pkg::STRANDS-1:0] store_resume_strands_o,
	output logic [core_pkg::LINE_BYTES-1:0] ack_mask_o,

	// L2 request
	output logic l2req_valid_o,
	input l2req_ready_i,
	output logic [$clog2(core_pkg::STRANDS)-1:0] l2req_strand_o,
	output logic [ADDR_W-1:0] l2req_address_o,
	output core_pkg::line_t l2req_data_o,
	output logic [core_pkg::LINE_BYTES-1:0] l2req_mask_o,

	// L2 response, already filtered by core
	input rsp_valid_i,
	input core_pkg::l2_unit_e rsp_unit_i,
	input [$clog2(core_pkg::STRANDS)-1:0] rsp_strand_i);

	localparam STRAND_W = $clog2(core_pkg::STRANDS);

	logic [core_pkg::STRANDS-1:0] pending_r;
	logic [core_pkg::STRANDS-1:0] issued_r;
	logic [ADDR_W-1:0] addr_r [core_pkg::STRANDS];
	core_pkg::line_t data_r [core_pkg::STRANDS];
	logic [core_pkg::LINE_BYTES-1:0] mask_r [core_pkg::STRANDS];

	logic sel_locked;	// Holds the choice while L2 is stalled
	logic [STRAND_W-1:0] sel_r;
	logic [STRAND_W-1:0] first_sel;
	logic [STRAND_W-1:0] issue_sel;

	wire [core_pkg::STRANDS-1:0] waiting = pending_r & ~issued_r;
	wire store_accept = store_i && !pending_r[strand_i];
	wire ack = rsp_valid_i && rsp_unit_i == core_pkg::UNIT_STBUF;
	wire bypass_match = pending_r[strand_i] && addr_r[strand_i] == addr_i;

	// Lowest numbered waiting entry
	always_comb
	begin
		first_sel = '0;
		for (int i = core_pkg::STRANDS - 1; i >= 0; i--)
		begin
			if (waiting[i])
				first_sel = STRAND_W'(i);
		end
	end

	assign issue_sel = sel_locked ? sel_r : first_sel;
	assign l2req_valid_o = |waiting;
	assign l2req_strand_o = issue_sel;
	assign l2req_address_o = addr_r[issue_sel];
	assign l2req_data_o = data_r[issue_sel];
	assign l2req_mask_o = mask_r[issue_sel];
	assign ack_mask_o = mask_r[rsp_strand_i];

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			pending_r <= '0;
			issued_r <= '0;
			sel_locked <= 1'b0;
			sel_r <= '0;
			rollback_o <= 1'b0;
			store_resume_strands_o <= '0;
			bypass_mask_o <= '0;
		end
		else
		begin
			if (ack)
			begin
				pending_r[rsp_strand_i] <= 1'b0;
				issued_r[rsp_strand_i] <= 1'b0;
			end

			if (l2req_valid_o && l2req_ready_i)
			begin
				issued_r[issue_sel] <= 1'b1;
				sel_locked <= 1'b0;
			end
			else if (l2req_valid_o)
			begin
				sel_locked <= 1'b1;
				sel_r <= issue_sel;
			end

			if (store_accept)
				pending_r[strand_i] <= 1'b1;

			rollback_o <= store_i && pending_r[strand_i];	// Entry still busy
			if (ack)
				store_resume_strands_o <= core_pkg::STRANDS'(1) << rsp_strand_i;
			else
				store_resume_strands_o <= '0;

			// Lined up with the cache lookup
			bypass_mask_o <= (load_i && bypass_match) ? mask_r[strand_i] : '0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (store_accept)
		begin
			addr_r[strand_i] <= addr_i;
			data_r[strand_i] <= store_data_i;
			mask_r[strand_i] <= store_mask_i;
		end
		bypass_data_o <= data_r[strand_i];
	end

endmodule

//--- rtl/l1_data_cache/l1_data_cache.sv
`timescale 1ns/1ps

module l1_data_cache
	#(parameter ADDR_W = 26,
	parameter SETS = 8)
	(input clk,
	input reset,

	// Pipeline side
	input load_i,
	input [$clog2(core_pkg::STRANDS)-1:0] strand_i,
	input [ADDR_W-1:0] addr_i,
	output core_pkg::line_t line_o,
	output logic hit_o,
	output logic load_collision_o,
	output logic [core_pkg::STRANDS-1:0] load_complete_strands_o,

	// L2 request
	output logic l2req_valid_o,
	input l2req_ready_i,
	output logic [$clog2(core_pkg::STRANDS)-1:0] l2req_strand_o,
	output logic [ADDR_W-1:0] l2req_address_o,

	// L2 response, already filtered by core
	input rsp_valid_i,
	input core_pkg::l2_unit_e rsp_unit_i,
	input [$clog2(core_pkg::STRANDS)-1:0] rsp_strand_i,
	input rsp_update_i,
	input [ADDR_W-1:0] rsp_address_i,
	input core_pkg::line_t rsp_data_i,
	input [core_pkg::LINE_BYTES-1:0] rsp_mask_i);

	localparam IDX_W = $clog2(SETS);
	localparam TAG_W = ADDR_W - IDX_W;
	localparam STRAND_W = $clog2(core_pkg::STRANDS);

	logic [TAG_W-1:0] tag_r [SETS];
	logic [SETS-1:0] valid_r;
	core_pkg::line_t line_r [SETS];

	logic load_q;
	logic [ADDR_W-1:0] addr_q;
	logic [STRAND_W-1:0] strand_q;
	logic miss_pending;	// Fill not yet returned
	logic req_valid;	// Request not yet taken by the arbiter
	logic [STRAND_W-1:0] miss_strand;
	logic [ADDR_W-1:0] miss_addr;

	wire [IDX_W-1:0] idx_q = addr_q[IDX_W-1:0];
	wire [TAG_W-1:0] tag_q = addr_q[ADDR_W-1:IDX_W];
	wire [IDX_W-1:0] rsp_idx = rsp_address_i[IDX_W-1:0];
	wire [TAG_W-1:0] rsp_tag = rsp_address_i[ADDR_W-1:IDX_W];

	wire lookup_hit = valid_r[idx_q] && tag_r[idx_q] == tag_q;
	wire miss = load_q && !lookup_hit;
	wire start_miss = miss && !miss_pending;

	wire fill = rsp_valid_i && rsp_unit_i == core_pkg::UNIT_DCACHE;

	// Write-through update only touches a line we already hold
	wire update = rsp_valid_i && rsp_unit_i == core_pkg::UNIT_STBUF && rsp_update_i
		&& valid_r[rsp_idx] && tag_r[rsp_idx] == rsp_tag;

	assign hit_o = load_q && lookup_hit;
	assign load_collision_o = miss && miss_pending;	// Only one miss at a time
	assign line_o = line_r[idx_q];
	assign l2req_valid_o = req_valid;
	assign l2req_strand_o = miss_strand;
	assign l2req_address_o = miss_addr;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			load_q <= 1'b0;
			miss_pending <= 1'b0;
			req_valid <= 1'b0;
			load_complete_strands_o <= '0;
		end
		else
		begin
			load_q <= load_i;
			if (start_miss)
			begin
				miss_pending <= 1'b1;
				req_valid <= 1'b1;
			end
			else
			begin
				if (req_valid && l2req_ready_i)
					req_valid <= 1'b0;
				if (fill)
					miss_pending <= 1'b0;
			end

			// Wake the waiting strand once the line is in
			if (fill)
				load_complete_strands_o <= core_pkg::STRANDS'(1) << rsp_strand_i;
			else
				load_complete_strands_o <= '0;
		end
	end

	always_ff @(posedge clk)
	begin
		addr_q <= addr_i;
		strand_q <= strand_i;
		if (start_miss)
		begin
			miss_strand <= strand_q;
			miss_addr <= addr_q;
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			valid_r <= '0;
		else if (fill)
			valid_r[rsp_idx] <= 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (fill)
		begin
			tag_r[rsp_idx] <= rsp_tag;
			line_r[rsp_idx] <= rsp_data_i;
		end
		else if (update)
		begin
			for (int i = 0; i < core_pkg::LINE_BYTES; i++)
			begin
				if (rsp_mask_i[i])
					line_r[rsp_idx].bytes[i] <= rsp_data_i.bytes[i];
			end
		end
	end

endmodule

//--- common/core_pkg.sv
package core_pkg;

	localparam int LINE_BYTES = 16;
	localparam int LINE_WORDS = 4;
	localparam int STRANDS = 4;

	// One cache line, addressed by byte or by word
	typedef union packed
	{
		logic [LINE_BYTES-1:0][7:0] bytes;
		logic [LINE_WORDS-1:0][31:0] words;
	} line_t;

	// L2 request operation
	typedef enum logic [2:0]
	{
		L2_OP_LOAD = 3'd0,
		L2_OP_STORE = 3'd1
	} l2_op_e;

	// Requesting unit, echoed back in the response
	typedef enum logic [1:0]
	{
		UNIT_DCACHE = 2'd1,
		UNIT_STBUF = 2'd2
	} l2_unit_e;

endpackage
